// ==== list.f ====
rtl/wed_pkg.sv
rtl/read_data_if.sv
rtl/wed_control.sv
rtl/wed_wait_timer.sv
rtl/wed_line_assembler.sv
rtl/wed_decoder.sv
rtl/wed_fetch_top.sv
testbench/wed_fetch_tb.sv

// ==== rtl/read_data_if.sv ====
`timescale 1ns/1ps

// One read-data port from the host side. Beats for all units share it,
// so the receiver filters on unit_id.
interface read_data_if;
  import wed_pkg::*;

  logic       valid;
  unit_id_t   unit_id;   // Owner of this beat
  logic       half;      // 0 low 512 bits, 1 high 512 bits
  half_line_t data;

  modport source (
    output valid,
    output unit_id,
    output half,
    output data
  );

  modport sink (
    input valid,
    input unit_id,
    input half,
    input data
  );

endinterface

// ==== rtl/wed_control.sv ====
`timescale 1ns/1ps

module wed_control (
  input  logic                 clock,
  input  logic                 rstn,
  input  logic                 enabled,
  input  wed_pkg::addr_t       wed_address,
  input  logic                 resp_valid,
  input  wed_pkg::unit_id_t    resp_unit_id,
  input  wed_pkg::resp_code_t  resp_code,
  input  logic                 cmd_alfull,
  input  logic                 line_full,
  input  logic                 timed_out,
  input  logic                 retries_exhausted,
  input  logic                 decoded,
  output logic                 cmd_valid,
  output wed_pkg::cmd_code_t   cmd_command,
  output wed_pkg::addr_t       cmd_address,
  output wed_pkg::xfer_size_t  cmd_size,
  output wed_pkg::unit_id_t    cmd_unit_id,
  output logic                 wait_run,
  output logic                 req_pulse,
  output logic                 capture_en,
  output logic                 clear,
  output logic                 decode_go,
  output logic                 wed_valid,
  output logic                 wed_error,
  output wed_pkg::addr_t       wed_req_address
);
  import wed_pkg::*;

  wed_state_t state, next_state;
  logic       resp_match;   // DONE for us in this cycle
  logic       resp_seen;    // DONE seen earlier in this wait
  logic       done_ok;

  assign resp_match = resp_valid && (resp_unit_id == wed_unit_id) && (resp_code == resp_done);
  assign done_ok    = resp_seen || resp_match;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn)
      state <= wed_reset;
    else
      state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      wed_reset: next_state = wed_idle;
      wed_idle: begin
        if (enabled && !cmd_alfull && !wed_valid)
          next_state = wed_req;
      end
      wed_req: next_state = wed_wait;
      wed_wait: begin
        if (done_ok && line_full)
          next_state = wed_decode;   // Data wins over a late timeout
        else if (timed_out)
          next_state = retries_exhausted ? wed_fail : wed_req;
      end
      wed_decode: next_state = wed_done;
      wed_done: next_state = wed_idle;   // Idle then holds on wed_valid
      wed_fail: next_state = wed_fail;
      default: next_state = wed_reset;
    endcase
  end

  // Strobes and levels straight from the state
  assign req_pulse  = (state == wed_req);
  assign clear      = (state == wed_req);
  assign wait_run   = (state == wed_wait);
  assign capture_en = (state == wed_wait);
  assign decode_go  = (state == wed_decode);
  assign wed_error  = (state == wed_fail);
  assign wed_valid  = decoded;

  // Response may come before or after the data
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn)
      resp_seen <= 1'b0;
    else if (state == wed_req)
      resp_seen <= 1'b0;
    else if (state == wed_wait && resp_match)
      resp_seen <= 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Command register, one pulse per request
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd_valid       <= 1'b0;
      cmd_command     <= cmd_invalid;
      cmd_address     <= '0;
      cmd_size        <= '0;
      cmd_unit_id     <= '0;
      wed_req_address <= '0;
    end else begin
      cmd_valid <= (state == wed_req);
      if (state == wed_req) begin
        cmd_command     <= read_cl_na;
        cmd_address     <= wed_address;
        cmd_size        <= wed_line_size;
        cmd_unit_id     <= wed_unit_id;
        wed_req_address <= wed_address;   // Kept for the consumer
      end
    end
  end

  // A second pulse would mean a duplicate read in flight
  assert property (@(posedge clock) disable iff (!rstn) cmd_valid |=> !cmd_valid);

  // Decoder flag and fail state must exclude each other
  assert property (@(posedge clock) disable iff (!rstn) !(wed_valid && wed_error));

endmodule

// ==== rtl/wed_decoder.sv ====
`timescale 1ns/1ps

module wed_decoder (
  input  logic                 clock,
  input  logic                 rstn,
  input  logic                 decode_go,
  input  wed_pkg::cache_line_t line,
  output logic                 decoded,
  output wed_pkg::count_t      vertex_count,
  output wed_pkg::count_t      edge_count,
  output wed_pkg::addr_t       vertex_in_ptr,
  output wed_pkg::addr_t       vertex_out_ptr,
  output wed_pkg::addr_t       edge_in_ptr,
  output wed_pkg::addr_t       edge_out_ptr
);
  import wed_pkg::*;

  // Host byte 0 sits in the top byte of the low half
  half_line_t head;

  assign head = line[511:0];

  // Reverses the low nbytes bytes of v
  function automatic logic [63:0] byte_rev(input logic [63:0] v, input int nbytes);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < nbytes; i++) begin
      r[8*i +: 8] = v[8*(nbytes-1-i) +: 8];
    end
    return r;
  endfunction

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      decoded        <= 1'b0;
      vertex_count   <= '0;
      edge_count     <= '0;
      vertex_in_ptr  <= '0;
      vertex_out_ptr <= '0;
      edge_in_ptr    <= '0;
      edge_out_ptr   <= '0;
    end else if (decode_go) begin
      decoded        <= 1'b1;   // Held until reset
      vertex_count   <= count_t'(byte_rev({32'h0, head[511 -: 32]}, 4));  // Bytes 0..3
      edge_count     <= count_t'(byte_rev({32'h0, head[479 -: 32]}, 4));  // Bytes 4..7
      vertex_in_ptr  <= byte_rev(head[447 -: 64], 8);   // Bytes 8..15
      vertex_out_ptr <= byte_rev(head[383 -: 64], 8);
      edge_in_ptr    <= byte_rev(head[319 -: 64], 8);
      edge_out_ptr   <= byte_rev(head[255 -: 64], 8);   // Bytes 32..39
    end
  end

endmodule

// ==== rtl/wed_fetch_top.sv ====
`timescale 1ns/1ps

module wed_fetch_top #(
  parameter int timeout_cycles = 64,
  parameter int max_retries    = 3
) (
  input  logic                 clock,
  input  logic                 rstn,
  input  logic                 enabled,
  input  wed_pkg::addr_t       wed_address,
  input  logic                 rd0_valid,
  input  wed_pkg::unit_id_t    rd0_unit_id,
  input  logic                 rd0_half,
  input  wed_pkg::half_line_t  rd0_data,
  input  logic                 rd1_valid,
  input  wed_pkg::unit_id_t    rd1_unit_id,
  input  logic                 rd1_half,
  input  wed_pkg::half_line_t  rd1_data,
  input  logic                 resp_valid,
  input  wed_pkg::unit_id_t    resp_unit_id,
  input  wed_pkg::resp_code_t  resp_code,
  input  logic                 cmd_alfull,
  output logic                 cmd_valid,
  output wed_pkg::cmd_code_t   cmd_command,
  output wed_pkg::addr_t       cmd_address,
  output wed_pkg::xfer_size_t  cmd_size,
  output wed_pkg::unit_id_t    cmd_unit_id,
  output logic                 wed_valid,
  output logic                 wed_error,
  output wed_pkg::addr_t       wed_req_address,
  output wed_pkg::count_t      vertex_count,
  output wed_pkg::count_t      edge_count,
  output wed_pkg::addr_t       vertex_in_ptr,
  output wed_pkg::addr_t       vertex_out_ptr,
  output wed_pkg::addr_t       edge_in_ptr,
  output wed_pkg::addr_t       edge_out_ptr
);
  import wed_pkg::*;

  logic        wait_run, req_pulse, timed_out, retries_exhausted;
  logic        capture_en, clear, line_full;
  logic        decode_go, decoded;
  cache_line_t line;

  //////////////////////////////////////////////////////////////////////
  // Read-data ports
  //////////////////////////////////////////////////////////////////////

  read_data_if rd0 ();
  read_data_if rd1 ();

  assign rd0.valid   = rd0_valid;
  assign rd0.unit_id = rd0_unit_id;
  assign rd0.half    = rd0_half;
  assign rd0.data    = rd0_data;

  assign rd1.valid   = rd1_valid;
  assign rd1.unit_id = rd1_unit_id;
  assign rd1.half    = rd1_half;
  assign rd1.data    = rd1_data;

  //////////////////////////////////////////////////////////////////////
  // Fetch blocks
  //////////////////////////////////////////////////////////////////////

  wed_control u_control (
    .clock, .rstn, .enabled, .wed_address,
    .resp_valid, .resp_unit_id, .resp_code, .cmd_alfull,
    .line_full, .timed_out, .retries_exhausted, .decoded,
    .cmd_valid, .cmd_command, .cmd_address, .cmd_size, .cmd_unit_id,
    .wait_run, .req_pulse, .capture_en, .clear, .decode_go,
    .wed_valid, .wed_error, .wed_req_address
  );

  wed_wait_timer #(
    .timeout_cycles (timeout_cycles),
    .max_retries    (max_retries)
  ) u_timer (
    .clock, .rstn, .wait_run, .req_pulse,
    .timed_out, .retries_exhausted
  );

  wed_line_assembler u_assembler (
    .clock, .rstn, .capture_en, .clear,
    .rd0 (rd0.sink),
    .rd1 (rd1.sink),
    .line, .line_full
  );

  wed_decoder u_decoder (
    .clock, .rstn, .decode_go, .line, .decoded,
    .vertex_count, .edge_count,
    .vertex_in_ptr, .vertex_out_ptr, .edge_in_ptr, .edge_out_ptr
  );

endmodule

// ==== rtl/wed_line_assembler.sv ====
`timescale 1ns/1ps

module wed_line_assembler (
  input  logic                 clock,
  input  logic                 rstn,
  input  logic                 capture_en,
  input  logic                 clear,
  read_data_if.sink            rd0,
  read_data_if.sink            rd1,
  output wed_pkg::cache_line_t line,
  output logic                 line_full
);
  import wed_pkg::*;

  logic       acc0, acc1;   // Beat taken from each port
  logic [1:0] hit;          // Halves landing this cycle
  logic [1:0] got;          // Halves already held

  assign acc0 = capture_en && rd0.valid && (rd0.unit_id == wed_unit_id);
  assign acc1 = capture_en && rd1.valid && (rd1.unit_id == wed_unit_id);

  assign hit[0] = (acc0 && !rd0.half) || (acc1 && !rd1.half);
  assign hit[1] = (acc0 && rd0.half) || (acc1 && rd1.half);

  // Counts a half that is written at this edge, so the line is
  // complete in the register by the time decode reads it
  assign line_full = &(got | hit);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn)
      got <= '0;
    else if (clear)
      got <= '0;
    else
      got <= got | hit;
  end

  // Line storage, written per half
  always_ff @(posedge clock) begin
    if (acc0)
      line[{rd0.half, 9'd0} +: 512] <= rd0.data;
    if (acc1)
      line[{rd1.half, 9'd0} +: 512] <= rd1.data;
  end

  // Host side must not send the same half on both ports at once
  assert property (@(posedge clock) disable iff (!rstn)
    !(acc0 && acc1 && (rd0.half == rd1.half)));

endmodule

// ==== rtl/wed_pkg.sv ====
package wed_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  //////////////////////////////////////////////////////////////////////

  typedef logic [63:0]   addr_t;        // Host byte address
  typedef logic [511:0]  half_line_t;   // One read-data beat
  typedef logic [1023:0] cache_line_t;  // Whole 128-byte line
  typedef logic [7:0]    unit_id_t;     // Compute-unit tag on cmd/resp/data
  typedef logic [31:0]   count_t;       // Vertex or edge count
  typedef logic [11:0]   xfer_size_t;   // Command transfer size in bytes

  //////////////////////////////////////////////////////////////////////
  // Ids and sizes
  //////////////////////////////////////////////////////////////////////

  localparam unit_id_t   wed_unit_id   = 8'h01;   // Tag of the WED fetch unit
  localparam xfer_size_t wed_line_size = 12'h080; // One full cache line

  //////////////////////////////////////////////////////////////////////
  // Command and response codes
  //////////////////////////////////////////////////////////////////////

  // Host read, line not allocated in the accelerator cache
  typedef enum logic [12:0] {
    cmd_invalid = 13'h0000,
    read_cl_na  = 13'h0A00
  } cmd_code_t;

  typedef enum logic [7:0] {
    resp_done  = 8'h00,
    resp_other = 8'h01   // Anything that is not DONE
  } resp_code_t;

  //////////////////////////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    wed_reset,   // First cycle out of reset
    wed_idle,
    wed_req,     // Latch and launch the read
    wed_wait,    // Gather response and both halves
    wed_decode,
    wed_done,
    wed_fail     // Sticky until reset
  } wed_state_t;

endpackage

// ==== rtl/wed_wait_timer.sv ====
`timescale 1ns/1ps

module wed_wait_timer #(
  parameter int timeout_cycles = 64,
  parameter int max_retries    = 3
) (
  input  logic clock,
  input  logic rstn,
  input  logic wait_run,
  input  logic req_pulse,
  output logic timed_out,
  output logic retries_exhausted
);

  localparam int cycle_w = $clog2(timeout_cycles + 1);
  localparam int retry_w = $clog2(max_retries + 2);

  logic [cycle_w-1:0] cycle_count;
  logic [retry_w-1:0] retry_count;

  // Fires in the last waiting cycle of the window
  assign timed_out = wait_run && (cycle_count == cycle_w'(timeout_cycles - 1));

  assign retries_exhausted = (retry_count >= retry_w'(max_retries));

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn)
      cycle_count <= '0;
    else if (req_pulse || timed_out)
      cycle_count <= '0;   // Fresh window per request
    else if (wait_run)
      cycle_count <= cycle_count + 1'b1;
  end

  // Counts up to the limit and then holds
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn)
      retry_count <= '0;
    else if (timed_out && !retries_exhausted)
      retry_count <= retry_count + 1'b1;
  end

  // A timeout is a single pulse inside a wait, never outside one
  assert property (@(posedge clock) disable iff (!rstn)
    timed_out |-> wait_run ##1 !timed_out);

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module wed_fetch_tb -o wed_fetch_sim

out=$(./obj_dir/wed_fetch_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// ==== testbench/wed_fetch_tb.sv ====
`timescale 1ns/1ps

module wed_fetch_tb;
  import wed_pkg::*;

  localparam int timeout_cycles = 20;
  localparam int max_retries    = 2;
  localparam int num_scen       = 14;
  localparam int vec_words      = 11;   // Words per vectors line
  localparam int wd_cycles = num_scen * (4 + (max_retries + 1) * (timeout_cycles + 40));
  localparam unit_id_t foreign_id = 8'h05;   // Some other compute unit
  localparam unit_id_t own_unit   = 8'h01;   // Id of the WED fetch unit
  localparam xfer_size_t line_bytes = 12'h080;   // One 128-byte line

  logic        clock, rstn, enabled, cmd_alfull;
  addr_t       wed_address;
  logic        rd0_valid, rd0_half, rd1_valid, rd1_half;
  unit_id_t    rd0_unit_id, rd1_unit_id;
  half_line_t  rd0_data, rd1_data;
  logic        resp_valid;
  unit_id_t    resp_unit_id;
  resp_code_t  resp_code;
  logic        cmd_valid, wed_valid, wed_error;
  cmd_code_t   cmd_command;
  addr_t       cmd_address, wed_req_address;
  xfer_size_t  cmd_size;
  unit_id_t    cmd_unit_id;
  count_t      vertex_count, edge_count;
  addr_t       vertex_in_ptr, vertex_out_ptr, edge_in_ptr, edge_out_ptr;

  logic [63:0] vec_mem [0:num_scen*vec_words-1];
  addr_t       exp_addr, exp_vin, exp_vout, exp_ein, exp_eout;
  count_t      exp_vc, exp_ec;
  cache_line_t exp_line;   // Line as host memory holds it
  int          delay_cycles, data_order, foreign_beats, drop_count;
  int          cmd_count;
  integer      seed;

  wed_fetch_top #(
    .timeout_cycles (timeout_cycles),
    .max_retries    (max_retries)
  ) dut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string name);
    if (got !== exp)
      fail_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_count(input count_t got, input count_t exp, input string name);
    if (got !== exp)
      fail_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_cmd(input cmd_code_t got, input cmd_code_t exp, input string name);
    if (got !== exp)
      fail_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_size(input xfer_size_t got, input xfer_size_t exp, input string name);
    if (got !== exp)
      fail_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_unit(input unit_id_t got, input unit_id_t exp, input string name);
    if (got !== exp)
      fail_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp)
      fail_run($sformatf("FAIL at %0t ns: %s is %b, expected %b", $time, name, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory-side model
  //////////////////////////////////////////////////////////////////////

  function automatic half_line_t random_half();
    half_line_t r;
    for (int i = 0; i < 16; i++)
      r[32*i +: 32] = $random(seed);
    return r;
  endfunction

  function automatic half_line_t beat_data(input logic v, input unit_id_t id, input logic h);
    if (!v)
      return '0;
    if (id == own_unit)
      return h ? exp_line[1023:512] : exp_line[511:0];
    return random_half();   // Junk for another unit
  endfunction

  // Host byte k of the low half sits at bits 511-8k down
  task automatic place_field(input int offset, input logic [63:0] value, input int nbytes);
    for (int i = 0; i < nbytes; i++)
      exp_line[511 - 8*(offset + i) -: 8] = value[8*i +: 8];
  endtask

  task automatic build_line();
    for (int i = 0; i < 32; i++)
      exp_line[32*i +: 32] = $random(seed);
    place_field(0, {32'h0, exp_vc}, 4);
    place_field(4, {32'h0, exp_ec}, 4);
    place_field(8, exp_vin, 8);
    place_field(16, exp_vout, 8);
    place_field(24, exp_ein, 8);
    place_field(32, exp_eout, 8);
  endtask

  // One cycle of read-data and response traffic
  task automatic drive_beats(input logic v0, input unit_id_t id0, input logic h0,
                             input logic v1, input unit_id_t id1, input logic h1,
                             input logic rv, input unit_id_t rid);
    @(posedge clock);
    rd0_valid    <= v0;
    rd0_unit_id  <= id0;
    rd0_half     <= h0;
    rd0_data     <= beat_data(v0, id0, h0);
    rd1_valid    <= v1;
    rd1_unit_id  <= id1;
    rd1_half     <= h1;
    rd1_data     <= beat_data(v1, id1, h1);
    resp_valid   <= rv;
    resp_unit_id <= rid;
    resp_code    <= resp_done;
    @(negedge clock);
  endtask

  task automatic drive_quiet();
    drive_beats(1'b0, '0, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic answer_request();
    unit_id_t own;
    own = own_unit;
    repeat (delay_cycles) drive_quiet();
    case (data_order)
      0: begin
        drive_beats(1'b1, own, 1'b0, 1'b0, own, 1'b0, 1'b0, own);   // Low half on rd0
        drive_beats(1'b1, own, 1'b1, 1'b0, own, 1'b0, 1'b0, own);
      end
      1: begin
        drive_beats(1'b0, own, 1'b0, 1'b0, own, 1'b0, 1'b1, own);   // Response first
        drive_beats(1'b0, own, 1'b0, 1'b1, own, 1'b1, 1'b0, own);   // High half on rd1
      end
      2: drive_beats(1'b1, own, 1'b1, 1'b1, own, 1'b0, 1'b0, own); // Halves split over ports
      default: begin
        drive_beats(1'b0, own, 1'b0, 1'b0, own, 1'b0, 1'b1, own);
        drive_beats(1'b1, own, 1'b1, 1'b0, own, 1'b0, 1'b0, own);
      end
    endcase
    check_bit(wed_valid, 1'b0, "wed_valid");
    if (foreign_beats != 0) begin
      // Foreign beats on both ports plus a foreign DONE
      drive_beats(1'b1, foreign_id, 1'b0, 1'b1, foreign_id, 1'b1, 1'b1, foreign_id);
      check_bit(wed_valid, 1'b0, "wed_valid");
    end
    case (data_order)
      0, 2: drive_beats(1'b0, own, 1'b0, 1'b0, own, 1'b0, 1'b1, own);
      1: drive_beats(1'b1, own, 1'b0, 1'b0, own, 1'b0, 1'b0, own);
      default: drive_beats(1'b0, own, 1'b0, 1'b1, own, 1'b0, 1'b0, own);
    endcase
    check_bit(wed_valid, 1'b0, "wed_valid");   // Wait ends in this cycle
    drive_quiet();
    check_bit(wed_valid, 1'b0, "wed_valid");   // Decode cycle
    drive_quiet();
    check_bit(wed_valid, 1'b1, "wed_valid");
    check_count(vertex_count, exp_vc, "vertex_count");
    check_count(edge_count, exp_ec, "edge_count");
    check_addr(vertex_in_ptr, exp_vin, "vertex_in_ptr");
    check_addr(vertex_out_ptr, exp_vout, "vertex_out_ptr");
    check_addr(edge_in_ptr, exp_ein, "edge_in_ptr");
    check_addr(edge_out_ptr, exp_eout, "edge_out_ptr");
    check_addr(wed_req_address, exp_addr, "wed_req_address");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scenario steps
  //////////////////////////////////////////////////////////////////////

  task automatic load_scenario(input int s);
    int base;
    base          = s * vec_words;
    exp_addr      = vec_mem[base];
    exp_vc        = count_t'(vec_mem[base+1]);
    exp_ec        = count_t'(vec_mem[base+2]);
    exp_vin       = vec_mem[base+3];
    exp_vout      = vec_mem[base+4];
    exp_ein       = vec_mem[base+5];
    exp_eout      = vec_mem[base+6];
    delay_cycles  = int'(vec_mem[base+7]);
    data_order    = int'(vec_mem[base+8]);
    foreign_beats = int'(vec_mem[base+9]);
    drop_count    = int'(vec_mem[base+10]);
    if ($isunknown(vec_mem[base+10]) || $isunknown(exp_addr) || exp_addr == '0)
      fail_run($sformatf("Vectors file is missing or short, scenario %0d is incomplete", s));
  endtask

  task automatic apply_reset();
    @(posedge clock);
    rstn        <= 1'b0;
    enabled     <= 1'b0;
    cmd_alfull  <= 1'b0;
    wed_address <= exp_addr;
    repeat (3) @(posedge clock);
    @(negedge clock);
    check_bit(cmd_valid, 1'b0, "cmd_valid");
    check_bit(wed_valid, 1'b0, "wed_valid");
    check_bit(wed_error, 1'b0, "wed_error");
    check_count(vertex_count, '0, "vertex_count");
    check_count(edge_count, '0, "edge_count");
    check_addr(vertex_in_ptr, '0, "vertex_in_ptr");
    check_addr(vertex_out_ptr, '0, "vertex_out_ptr");
    check_addr(edge_in_ptr, '0, "edge_in_ptr");
    check_addr(edge_out_ptr, '0, "edge_out_ptr");
    @(posedge clock);
    rstn <= 1'b1;
  endtask

  // Enable with cmd_alfull held, then release it
  task automatic hold_backpressure();
    @(posedge clock);
    enabled    <= 1'b1;
    cmd_alfull <= 1'b1;
    repeat (6) @(posedge clock);
    check_count(count_t'(cmd_count), '0, "cmd_valid pulses");
    cmd_alfull <= 1'b0;
  endtask

  task automatic run_requests();
    int n_req;
    n_req = (drop_count > max_retries) ? max_retries + 1 : drop_count + 1;
    for (int r = 0; r < n_req; r++) begin
      wait (cmd_count > r);
      if (r == drop_count)
        answer_request();
    end
    if (drop_count > max_retries)
      wait (wed_error === 1'b1);
    // Levels hold and no new command appears
    repeat (30) begin
      @(negedge clock);
      check_bit(wed_valid, drop_count <= max_retries, "wed_valid");
      check_bit(wed_error, drop_count > max_retries, "wed_error");
    end
    @(posedge clock);
    check_count(count_t'(cmd_count), count_t'(n_req), "cmd_valid pulses");
  endtask

  // Command monitor, sampled mid-cycle
  always @(negedge clock) begin
    if (!rstn) begin
      cmd_count = 0;
    end else if (cmd_valid) begin
      cmd_count = cmd_count + 1;
      if (cmd_alfull)
        fail_run("A read command was issued while cmd_alfull was held high");
      check_cmd(cmd_command, read_cl_na, "cmd_command");
      check_addr(cmd_address, exp_addr, "cmd_address");
      check_size(cmd_size, line_bytes, "cmd_size");
      check_unit(cmd_unit_id, own_unit, "cmd_unit_id");
    end
  end

  initial begin
    repeat (wd_cycles) @(posedge clock);
    fail_run("Simulation hung, the watchdog expired before all scenarios finished");
  end

  initial begin
    seed         = 32'h2756195d;
    rstn         = 1'b0;
    enabled      = 1'b0;
    cmd_alfull   = 1'b0;
    wed_address  = '0;
    rd0_valid    = 1'b0;
    rd0_unit_id  = '0;
    rd0_half     = 1'b0;
    rd0_data     = '0;
    rd1_valid    = 1'b0;
    rd1_unit_id  = '0;
    rd1_half     = 1'b0;
    rd1_data     = '0;
    resp_valid   = 1'b0;
    resp_unit_id = '0;
    resp_code    = resp_done;
    $readmemh("testbench/wed_fetch_vectors.txt", vec_mem);
    for (int s = 0; s < num_scen; s++) begin
      load_scenario(s);
      build_line();
      apply_reset();
      hold_backpressure();
      run_requests();
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== testbench/wed_fetch_vectors.txt ====
// address vertex_count edge_count vertex_in vertex_out edge_in edge_out (hex)
// then delay order(0..3) foreign(0/1) drop(requests left unanswered)
7f0000010000 00000010 00000040 7f0000200000 7f0000201000 7f0000300000 7f0000304000 0 0 0 0
7f0000020080 00001234 0000abcd 7f1122334400 7f1122335500 7f2233445500 7f2233446600 2 1 0 0
7f0000030100 0badf00d 12345678 0123456789abcdef fedcba9876543210 0011223344556677 8899aabbccddeeff 5 2 0 0
7f0000040180 00000001 00000000 7f00a0000000 7f00a0000040 7f00b0000000 7f00b0000080 1 3 1 0
7f0000050200 00010000 00080000 7e0000000000 7e0000100000 7e0000200000 7e0000300000 3 0 1 0
7f0000060280 000000ff 00000fff 7f0c00000000 7f0c00010000 7f0d00000000 7f0d00020000 0 1 1 1
7f0000070300 00c0ffee 00beef00 7f1000000000 7f1000000400 7f1100000000 7f1100000800 4 2 0 2
7f0000080380 00000020 00000080 7f2000000000 7f2000001000 7f2100000000 7f2100002000 0 0 0 3
7f0000090400 7fffffff 80000000 7f3000000000 7f3000000008 7f3100000000 7f3100000010 8 3 0 0
7f00000a0480 00000500 00002800 a1b2c3d4e5f60718 1827364554637281 7f4100000000 7f4100002800 4 2 1 0
7f00000b0500 00000003 00000006 7f5000000000 7f5000000100 7f5100000000 7f5100000200 6 0 0 1
7f00000c0580 00000042 00000084 7f6000000000 7f6000001000 7f6100000000 7f6100002000 2 1 1 3
7f00000d0600 01020304 05060708 7f7000000000 7f7000000800 7f7100000000 7f7100001000 7 1 1 2
7f00000e0680 ffffffff ffffffff ffffffffffffffff fffffffffffffff8 8000000000000000 0000000000000001 0 0 0 0
